/* all.f */
+incdir+include
rtl/rv32_isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/reset_sequencer.sv
rtl/instr_decoder.sv
rtl/exec_sequencer.sv
rtl/ctrl_matrix.sv
test/ctrl_matrix_asserts.sv
test/ctrl_matrix_tb.sv

/* include/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// ----------------------------------------------------------------------
// Datapath widths seen by the control unit
// ----------------------------------------------------------------------

// Instruction and data word
`define CTRL_XLEN 32

// Register file index (x0..x31)
`define CTRL_REG_IDX_W 5

// ALU operation, funct3 plus the upper funct7 bits
`define CTRL_ALU_OP_W 6

// ALU flags V, N, C, Z
`define CTRL_FLAG_W 4

`endif

/* rtl/ctrl_matrix.sv */
`timescale 1ns/10ps

module ctrl_matrix
    import rv32_isa_pkg::*, ctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       mem_busy_i,
    input  instr_t     instr_i,
    input  flags_t     flags_i,
    output ctrl_word_t ctrl_o,
    output logic       ready_o,
    output logic       halt_o
);

    main_state_e state;
    ctrl_word_t  rst_ctrl;
    ctrl_word_t  exe_ctrl;
    ctrl_word_t  fetch_ctrl;
    ctrl_word_t  decode_ctrl;
    decode_t     dec;
    logic        rst_done;
    logic        exe_done;
    logic        exe_halted;

    reset_sequencer u_reset_seq (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .active_i (state == RESET),
        .ctrl_o   (rst_ctrl),
        .done_o   (rst_done)
    );

    instr_decoder u_decoder (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    exec_sequencer u_exec_seq (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .start_i  (state == DECODE),
        .dec_i    (dec),
        .flags_i  (flags_i),
        .ctrl_o   (exe_ctrl),
        .done_o   (exe_done),
        .halted_o (exe_halted)
    );

    // ------------------------------------------------------------------
    // Main state
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            state <= RESET;
        end else begin
            case (state)
                RESET:   state <= rst_done ? FETCH : RESET;
                // Hold until memory has the instruction
                FETCH:   state <= mem_busy_i ? FETCH : DECODE;
                DECODE:  state <= EXECUTE;
                default: state <= exe_done ? FETCH : EXECUTE;
            endcase
        end
    end

    // Load IR and PC prior once memory is ready
    always_comb begin
        fetch_ctrl = CTRL_IDLE;
        if (!mem_busy_i) begin
            fetch_ctrl.ir_ld  = 1'b0;
            fetch_ctrl.pcp_ld = 1'b0;
        end
    end

    // PC + 4 through the ALU defaults during decode
    always_comb begin
        decode_ctrl        = CTRL_IDLE;
        decode_ctrl.alu_ld = 1'b0;
        decode_ctrl.pc_ld  = 1'b0;
    end

    always_comb begin
        case (state)
            RESET:   ctrl_o = rst_ctrl;
            FETCH:   ctrl_o = fetch_ctrl;
            DECODE:  ctrl_o = decode_ctrl;
            default: ctrl_o = exe_ctrl;
        endcase
    end

    // Ready from the last vector cycle on, until a halt
    assign halt_o  = (state == EXECUTE) && exe_halted;
    assign ready_o = (state == RESET) ? rst_done : !halt_o;

endmodule

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

`include "ctrl_params.svh"

    import rv32_isa_pkg::*;

    // ------------------------------------------------------------------
    // Sequencer states
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {RESET, FETCH, DECODE, EXECUTE} main_state_e;

    typedef enum logic [2:0] {SYNC0, VECTOR0, VECTOR1, VECTOR2, VECTOR3} vector_state_e;

    // Execute sub-states, one per cycle
    typedef enum logic [4:0] {
        EX_RTYPE, EX_IALU, EX_ALU_WB,
        EX_LOAD, EX_LD_ACC, EX_LD_MDR, EX_LD_WB,
        EX_STORE, EX_ST_ACC, EX_ST_WR,
        EX_BRANCH, EX_BR_TAKE,
        EX_JAL, EX_JALR, EX_LINK,
        EX_LUI, EX_AUIPC,
        PREFETCH, HALT
    } exec_state_e;

    // ------------------------------------------------------------------
    // Datapath multiplexer selects
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {PC_ALU_IMM, PC_RST_VEC, PC_RST_ADR} pc_src_e;
    typedef enum logic [1:0] {A_PC, A_RS1, A_PRIOR, A_ZERO} a_src_e;
    typedef enum logic [1:0] {B_FOUR, B_RS2, B_IMM} b_src_e;
    typedef enum logic [1:0] {WD_IMM, WD_ALU, WD_MDR} wd_src_e;

    typedef struct packed {
        logic [2:0]                funct3;
        logic [`CTRL_ALU_OP_W-4:0] funct7up;
    } alu_op_t;

    localparam alu_op_t ALU_ADD = '{funct3: 3'b000, funct7up: 3'b000};
    // Bit 30 set selects subtract
    localparam alu_op_t ALU_SUB = '{funct3: 3'b000, funct7up: 3'b010};

    // One cycle of datapath control, strobes active low
    typedef struct packed {
        logic    pc_ld;
        logic    pcp_ld;
        logic    ir_ld;
        logic    mdr_ld;
        logic    alu_ld;
        logic    flags_ld;
        logic    rg_wr;
        logic    mem_rd;
        logic    mem_wr;
        pc_src_e pc_src;
        logic    addr_src;
        logic    rst_src;
        a_src_e  a_src;
        b_src_e  b_src;
        wd_src_e wd_src;
        alu_op_t alu_op;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '{
        pc_ld: 1'b1, pcp_ld: 1'b1, ir_ld: 1'b1, mdr_ld: 1'b1, alu_ld: 1'b1,
        flags_ld: 1'b1, rg_wr: 1'b1, mem_rd: 1'b1, mem_wr: 1'b1,
        pc_src: PC_ALU_IMM, addr_src: 1'b0, rst_src: 1'b0,
        a_src: A_PC, b_src: B_FOUR, wd_src: WD_IMM, alu_op: ALU_ADD
    };

    // Decoder result handed to the execute sequencer
    typedef struct packed {
        exec_state_e first_state;
        alu_op_t     alu_op;
        logic        rd_is_x0;
        logic        is_word;
        logic        is_shift;
        branch_f3_e  branch_f3;
    } decode_t;

endpackage

/* rtl/exec_sequencer.sv */
`timescale 1ns/10ps

module exec_sequencer
    import rv32_isa_pkg::*, ctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       start_i,
    input  decode_t    dec_i,
    input  flags_t     flags_i,
    output ctrl_word_t ctrl_o,
    output logic       done_o,
    output logic       halted_o
);

    exec_state_e state;
    exec_state_e next_state;
    logic        take_branch;

    // ------------------------------------------------------------------
    // Branch condition from the flags latched in EX_BRANCH
    // ------------------------------------------------------------------
    always_comb begin
        case (dec_i.branch_f3)
            BEQ:     take_branch = flags_i.z;
            BNE:     take_branch = !flags_i.z;
            // Signed compare, N != V means rs1 < rs2
            BLT:     take_branch = flags_i.n ^ flags_i.v;
            BGE:     take_branch = !(flags_i.n ^ flags_i.v);
            // Unsigned compare on borrow
            BLTU:    take_branch = flags_i.c;
            BGEU:    take_branch = !flags_i.c;
            default: take_branch = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // Control word and next sub-state
    // ------------------------------------------------------------------
    always_comb begin
        ctrl_o     = CTRL_IDLE;
        next_state = PREFETCH;
        case (state)
            EX_RTYPE, EX_IALU: begin
                // Compute into ALUOut, rs2 or immediate as operand B
                ctrl_o.alu_ld = 1'b0;
                ctrl_o.a_src  = A_RS1;
                ctrl_o.b_src  = (state == EX_RTYPE) ? B_RS2 : B_IMM;
                ctrl_o.alu_op = dec_i.alu_op;
                // Writing x0 is pointless, skip writeback
                next_state    = dec_i.rd_is_x0 ? PREFETCH : EX_ALU_WB;
            end
            EX_ALU_WB: begin
                ctrl_o.wd_src = WD_ALU;
                ctrl_o.rg_wr  = 1'b0;
            end
            EX_LOAD, EX_STORE: begin
                // Effective address rs1 + imm
                ctrl_o.alu_ld   = 1'b0;
                ctrl_o.a_src    = A_RS1;
                ctrl_o.b_src    = B_IMM;
                ctrl_o.addr_src = (state == EX_STORE);
                if (state == EX_LOAD) begin
                    next_state = EX_LD_ACC;
                end else begin
                    // Sub-word stores read the old word for merging
                    next_state = dec_i.is_word ? EX_ST_WR : EX_ST_ACC;
                end
            end
            EX_LD_ACC: begin
                ctrl_o.mem_rd   = 1'b0;
                ctrl_o.addr_src = 1'b1;
                next_state      = EX_LD_MDR;
            end
            EX_LD_MDR: begin
                // Read data valid, capture it
                ctrl_o.mem_rd   = 1'b0;
                ctrl_o.addr_src = 1'b1;
                ctrl_o.mdr_ld   = 1'b0;
                next_state      = EX_LD_WB;
            end
            EX_LD_WB: begin
                ctrl_o.wd_src = WD_MDR;
                ctrl_o.rg_wr  = 1'b0;
            end
            EX_ST_ACC: begin
                ctrl_o.mem_rd   = 1'b0;
                ctrl_o.addr_src = 1'b1;
                next_state      = EX_ST_WR;
            end
            EX_ST_WR: begin
                ctrl_o.addr_src = 1'b1;
                ctrl_o.mem_wr   = 1'b0;
            end
            EX_BRANCH: begin
                // rs1 - rs2 sets the flags only
                ctrl_o.a_src    = A_RS1;
                ctrl_o.b_src    = B_RS2;
                ctrl_o.alu_op   = ALU_SUB;
                ctrl_o.flags_ld = 1'b0;
                next_state      = EX_BR_TAKE;
            end
            EX_BR_TAKE: begin
                // Target PC prior + imm, loaded only when taken
                ctrl_o.alu_ld = 1'b0;
                ctrl_o.a_src  = A_PRIOR;
                ctrl_o.b_src  = B_IMM;
                ctrl_o.pc_ld  = !take_branch;
            end
            EX_JAL, EX_JALR: begin
                // jal is PC relative, jalr is rs1 relative
                ctrl_o.a_src = (state == EX_JAL) ? A_PRIOR : A_RS1;
                ctrl_o.b_src = B_IMM;
                ctrl_o.pc_ld = 1'b0;
                next_state   = dec_i.rd_is_x0 ? PREFETCH : EX_LINK;
            end
            EX_LINK: begin
                // Return address PC prior + 4
                ctrl_o.a_src  = A_PRIOR;
                ctrl_o.wd_src = WD_IMM;
                ctrl_o.rg_wr  = 1'b0;
            end
            EX_LUI, EX_AUIPC: begin
                // lui adds to zero, auipc to PC prior
                ctrl_o.a_src  = (state == EX_LUI) ? A_ZERO : A_PRIOR;
                ctrl_o.b_src  = B_IMM;
                ctrl_o.wd_src = WD_IMM;
                ctrl_o.rg_wr  = 1'b0;
            end
            // Read the next instruction at the new PC
            PREFETCH: ctrl_o.mem_rd = 1'b0;
            // Parked until reset
            HALT:     next_state = HALT;
            default:  ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            state <= PREFETCH;
        end else if (start_i) begin
            state <= dec_i.first_state;
        end else begin
            state <= next_state;
        end
    end

    assign done_o   = (state == PREFETCH);
    assign halted_o = (state == HALT);

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder
    import rv32_isa_pkg::*, ctrl_pkg::*;
(
    input  instr_t  instr_i,
    output decode_t dec_o
);

    logic    is_shift;
    alu_op_t full_op;
    alu_op_t imm_op;

    // slli, srli and srai keep funct7up to tell srl from sra
    assign is_shift = (instr_i.funct3 == 3'b001) || (instr_i.funct3 == 3'b101);

    assign full_op = '{funct3: instr_i.funct3, funct7up: instr_i.funct7up};
    // Immediate bits in funct7up position must not leak into the op
    assign imm_op  = '{funct3: instr_i.funct3, funct7up: 3'b000};

    always_comb begin
        dec_o.alu_op    = ALU_ADD;
        dec_o.rd_is_x0  = (instr_i.rd == '0);
        // Size bits 1:0 of funct3, word is 2'b10
        dec_o.is_word   = (instr_i.funct3[1:0] == 2'b10);
        dec_o.is_shift  = is_shift;
        dec_o.branch_f3 = branch_f3_e'(instr_i.funct3);

        case (instr_i.opcode)
            RTYPE: begin
                dec_o.first_state = EX_RTYPE;
                dec_o.alu_op      = full_op;
            end
            ITYPE: begin
                dec_o.first_state = EX_IALU;
                dec_o.alu_op      = is_shift ? full_op : imm_op;
            end
            ITYPE_L: dec_o.first_state = EX_LOAD;
            ITYPE_J: dec_o.first_state = EX_JALR;
            STYPE:   dec_o.first_state = EX_STORE;
            BTYPE:   dec_o.first_state = EX_BRANCH;
            JTYPE:   dec_o.first_state = EX_JAL;
            UTYPE_L: dec_o.first_state = EX_LUI;
            UTYPE_A: dec_o.first_state = EX_AUIPC;
            SYSTEM: begin
                // ebreak has imm bit 20 set, the rest of SYSTEM is a NOP
                if (instr_i.funct3 == 3'b000 && instr_i.rs2[0]) begin
                    dec_o.first_state = HALT;
                end else begin
                    dec_o.first_state = PREFETCH;
                end
            end
            // Unknown opcode, straight to the next fetch
            default: dec_o.first_state = PREFETCH;
        endcase
    end

endmodule

/* rtl/reset_sequencer.sv */
`timescale 1ns/10ps

module reset_sequencer
    import ctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       active_i,
    output ctrl_word_t ctrl_o,
    output logic       done_o
);

    vector_state_e state;

    // Sync to the first edge after release and then walk the vector
    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            state <= SYNC0;
        end else begin
            case (state)
                SYNC0:   state <= active_i ? VECTOR0 : SYNC0;
                VECTOR0: state <= VECTOR1;
                VECTOR1: state <= VECTOR2;
                VECTOR2: state <= VECTOR3;
                default: state <= SYNC0;
            endcase
        end
    end

    always_comb begin
        ctrl_o = CTRL_IDLE;
        // Reset source selected for the whole sequence
        ctrl_o.rst_src = 1'b1;
        case (state)
            VECTOR0: begin
                // PC takes the reset vector constant
                ctrl_o.pc_ld  = 1'b0;
                ctrl_o.pc_src = PC_RST_VEC;
            end
            // Read the start address stored at the vector
            VECTOR1: ctrl_o.mem_rd = 1'b0;
            VECTOR2: begin
                // PC takes the start address from memory
                ctrl_o.pc_ld  = 1'b0;
                ctrl_o.pc_src = PC_RST_ADR;
            end
            // First instruction read
            VECTOR3: ctrl_o.mem_rd = 1'b0;
            default: ;
        endcase
    end

    assign done_o = (state == VECTOR3);

endmodule

/* rtl/rv32_isa_pkg.sv */
package rv32_isa_pkg;

`include "ctrl_params.svh"

    // ------------------------------------------------------------------
    // Major opcodes of the RV32I base set
    // ------------------------------------------------------------------
    typedef enum logic [6:0] {
        RTYPE   = 7'b0110011,
        ITYPE   = 7'b0010011,
        ITYPE_L = 7'b0000011,
        ITYPE_J = 7'b1100111,
        STYPE   = 7'b0100011,
        BTYPE   = 7'b1100011,
        JTYPE   = 7'b1101111,
        UTYPE_L = 7'b0110111,
        UTYPE_A = 7'b0010111,
        SYSTEM  = 7'b1110011
    } opcode_e;

    // Branch conditions carried in funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

    // IR field split, MSB first
    // funct7up holds bits 31:29, which qualify sub and sra
    typedef struct packed {
        logic [2:0]                 funct7up;
        logic [3:0]                 funct7lo;
        logic [`CTRL_REG_IDX_W-1:0] rs2;
        logic [`CTRL_REG_IDX_W-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`CTRL_REG_IDX_W-1:0] rd;
        opcode_e                    opcode;
    } instr_t;

    // ALU flags as latched by flags_ld
    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } flags_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f all.f --top-module ctrl_matrix_tb --Mdir obj_dir -o sim_ctrl

status=0
./obj_dir/sim_ctrl +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
exit 0

/* test/ctrl_matrix_asserts.sv */
`timescale 1ns/10ps

module ctrl_matrix_asserts
    import ctrl_pkg::*;
(
    input logic       clk_i,
    input logic       reset_i,
    input ctrl_word_t ctrl_i,
    input logic       halt_i
);

    ctrl_word_t rst_word;
    logic       in_reset;
    int         assert_fails = 0;

    // Idle word with the reset source selected
    always_comb begin
        rst_word         = CTRL_IDLE;
        rst_word.rst_src = 1'b1;
    end

    // Reset was low at the previous edge too
    always_ff @(posedge clk_i) begin
        in_reset <= !reset_i;
    end

    // ----------------------------------------------------------------------
    // Control word sanity
    // ----------------------------------------------------------------------
    mem_exclusive: assert property (@(posedge clk_i) disable iff (!reset_i)
        ctrl_i.mem_rd || ctrl_i.mem_wr)
        else begin
            $error("mem_rd and mem_wr low in the same cycle");
            assert_fails++;
        end

    reset_idle: assert property (@(posedge clk_i)
        (in_reset && !reset_i) |-> (ctrl_i == rst_word))
        else begin
            $error("control word not idle during reset");
            assert_fails++;
        end

    // Halt only clears through reset
    halt_sticky: assert property (@(posedge clk_i) disable iff (!reset_i)
        halt_i |=> halt_i)
        else begin
            $error("halt dropped without reset");
            assert_fails++;
        end

endmodule

bind ctrl_matrix ctrl_matrix_asserts u_asserts (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ctrl_i  (ctrl_o),
    .halt_i  (halt_o)
);

/* test/ctrl_matrix_tb.sv */
`timescale 1ns/10ps
`include "ctrl_params.svh"

module ctrl_matrix_tb
    import rv32_isa_pkg::*, ctrl_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int N_INSTR    = 400;

    logic       clk_i;
    logic       reset_i;
    logic       mem_busy_i;
    instr_t     instr_i;
    flags_t     flags_i;
    ctrl_word_t ctrl_o;
    logic       ready_o;
    logic       halt_o;

    // Reference model state
    main_state_e m_main;
    int          m_vec;
    int          m_step;
    int          m_len;
    logic        m_halt;
    instr_t      m_ins;
    main_state_e prev_main;

    integer seed;
    int     ctrl_errs;
    int     bit_errs;
    int     n_instr;
    int     rst_left;
    int     halt_wait;
    int     busy_left;

    ctrl_matrix DUT (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .mem_busy_i (mem_busy_i),
        .instr_i    (instr_i),
        .flags_i    (flags_i),
        .ctrl_o     (ctrl_o),
        .ready_o    (ready_o),
        .halt_o     (halt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // About 12 cycles per instruction worst case plus reset and slack
    initial begin
        #(CLK_PERIOD * (N_INSTR * 12 + 200));
        $display("Watchdog expired after %0d instructions, the run did not finish", n_instr);
        $display("Simulation failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Timing rules of the control unit
    // ----------------------------------------------------------------------
    function automatic int exec_len(instr_t ins);
        case (ins.opcode)
            RTYPE, ITYPE, ITYPE_J, JTYPE: return (ins.rd == '0) ? 1 : 2;
            ITYPE_L:                      return 4;
            // Sub-word stores need the read for merging
            STYPE:                        return (ins.funct3[1:0] == 2'b10) ? 2 : 3;
            BTYPE:                        return 2;
            UTYPE_L, UTYPE_A:             return 1;
            default:                      return 0;
        endcase
    endfunction

    function automatic logic is_ebreak(instr_t ins);
        return (ins.opcode == SYSTEM) && (ins.funct3 == 3'b000) && ins[20];
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, flags_t f);
        case (f3)
            3'b000:  return f.z;
            3'b001:  return !f.z;
            3'b100:  return f.n != f.v;
            3'b101:  return f.n == f.v;
            3'b110:  return f.c;
            3'b111:  return !f.c;
            default: return 1'b0;
        endcase
    endfunction

    // Expected word for each execute step with PREFETCH at step len
    function automatic ctrl_word_t exec_word(instr_t ins, int step, int len, flags_t f);
        ctrl_word_t w;
        logic       shift;
        w     = CTRL_IDLE;
        shift = (ins.funct3[1:0] == 2'b01);
        if (step == len) begin
            w.mem_rd = 1'b0;
            return w;
        end
        case (ins.opcode)
            RTYPE, ITYPE: begin
                if (step == 0) begin
                    w.alu_ld          = 1'b0;
                    w.a_src           = A_RS1;
                    w.b_src           = (ins.opcode == RTYPE) ? B_RS2 : B_IMM;
                    w.alu_op.funct3   = ins.funct3;
                    // Bits 31:29 only matter for register ops and shifts
                    w.alu_op.funct7up = (ins.opcode == RTYPE || shift) ? ins[31:29] : 3'b000;
                end else begin
                    w.wd_src = WD_ALU;
                    w.rg_wr  = 1'b0;
                end
            end
            ITYPE_L, STYPE: begin
                if (step == 0) begin
                    w.alu_ld   = 1'b0;
                    w.a_src    = A_RS1;
                    w.b_src    = B_IMM;
                    w.addr_src = (ins.opcode == STYPE);
                end else if (ins.opcode == STYPE && step == len - 1) begin
                    w.addr_src = 1'b1;
                    w.mem_wr   = 1'b0;
                end else if (step == 3) begin
                    w.wd_src = WD_MDR;
                    w.rg_wr  = 1'b0;
                end else begin
                    // MDR captures the read data in the second load cycle
                    w.addr_src = 1'b1;
                    w.mem_rd   = 1'b0;
                    w.mdr_ld   = (step != 2);
                end
            end
            BTYPE: begin
                if (step == 0) begin
                    w.a_src    = A_RS1;
                    w.b_src    = B_RS2;
                    w.alu_op   = ALU_SUB;
                    w.flags_ld = 1'b0;
                end else begin
                    w.alu_ld = 1'b0;
                    w.a_src  = A_PRIOR;
                    w.b_src  = B_IMM;
                    w.pc_ld  = !branch_taken(ins.funct3, f);
                end
            end
            JTYPE, ITYPE_J: begin
                if (step == 0) begin
                    w.a_src = (ins.opcode == JTYPE) ? A_PRIOR : A_RS1;
                    w.b_src = B_IMM;
                    w.pc_ld = 1'b0;
                end else begin
                    w.a_src  = A_PRIOR;
                    w.wd_src = WD_IMM;
                    w.rg_wr  = 1'b0;
                end
            end
            UTYPE_L, UTYPE_A: begin
                w.a_src  = (ins.opcode == UTYPE_L) ? A_ZERO : A_PRIOR;
                w.b_src  = B_IMM;
                w.wd_src = WD_IMM;
                w.rg_wr  = 1'b0;
            end
            default: ;
        endcase
        return w;
    endfunction

    // Weighted opcode mix with rd = x0 about one time in four
    function automatic instr_t random_instr();
        instr_t ins;
        int     pick;
        ins  = $random(seed);
        pick = $random(seed) & 31;
        if (pick < 6) ins.opcode = RTYPE;
        else if (pick < 12) ins.opcode = ITYPE;
        else if (pick < 15) ins.opcode = ITYPE_L;
        else if (pick < 19) ins.opcode = STYPE;
        else if (pick < 23) ins.opcode = BTYPE;
        else if (pick < 25) ins.opcode = JTYPE;
        else if (pick < 27) ins.opcode = ITYPE_J;
        else if (pick < 28) ins.opcode = UTYPE_L;
        else if (pick < 29) ins.opcode = UTYPE_A;
        else if (pick < 30) ins.opcode = SYSTEM;
        else if (pick == 30) begin
            ins.opcode = SYSTEM;
            ins.funct3 = 3'b000;
            ins[20]    = 1'b1;
        end else ins.opcode = opcode_e'(7'b1111111);
        if (($random(seed) & 3) == 0) ins.rd = '0;
        return ins;
    endfunction

    // ----------------------------------------------------------------------
    // Model step, compare and stimulus
    // ----------------------------------------------------------------------
    task automatic advance_model();
        if (!reset_i) begin
            m_main = RESET;
            m_vec  = 0;
            m_halt = 1'b0;
        end else begin
            case (m_main)
                RESET: begin
                    if (m_vec == 4) begin
                        m_main = FETCH;
                        m_vec  = 0;
                    end else m_vec++;
                end
                FETCH: if (!mem_busy_i) m_main = DECODE;
                DECODE: begin
                    m_main = EXECUTE;
                    m_step = 0;
                    m_len  = exec_len(m_ins);
                    m_halt = is_ebreak(m_ins);
                end
                default: begin
                    if (!m_halt && m_step == m_len) m_main = FETCH;
                    else if (!m_halt) m_step++;
                end
            endcase
        end
    endtask

    task automatic check_ctrl(string name, ctrl_word_t exp, ctrl_word_t act);
        if (act !== exp) begin
            ctrl_errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            bit_errs++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_cycle();
        ctrl_word_t w;
        logic       exp_ready;
        logic       exp_halt;
        string      name;
        w         = CTRL_IDLE;
        exp_ready = 1'b1;
        exp_halt  = 1'b0;
        case (m_main)
            RESET: begin
                name      = $sformatf("vector step %0d", m_vec);
                w.rst_src = 1'b1;
                exp_ready = (m_vec == 4);
                if (m_vec == 1 || m_vec == 3) begin
                    w.pc_ld  = 1'b0;
                    w.pc_src = (m_vec == 1) ? PC_RST_VEC : PC_RST_ADR;
                end
                if (m_vec == 2 || m_vec == 4) w.mem_rd = 1'b0;
            end
            FETCH: begin
                name = "fetch";
                if (!mem_busy_i) begin
                    w.ir_ld  = 1'b0;
                    w.pcp_ld = 1'b0;
                end
            end
            DECODE: begin
                name     = "decode";
                w.alu_ld = 1'b0;
                w.pc_ld  = 1'b0;
            end
            default: begin
                name = $sformatf("execute opcode %h step %0d", m_ins.opcode, m_step);
                if (m_halt) begin
                    exp_ready = 1'b0;
                    exp_halt  = 1'b1;
                end else w = exec_word(m_ins, m_step, m_len, flags_i);
            end
        endcase
        check_ctrl(name, w, ctrl_o);
        check_bit({name, " ready"}, exp_ready, ready_o);
        check_bit({name, " halt"}, exp_halt, halt_o);
    endtask

    task automatic drive_inputs(logic new_fetch);
        logic [`CTRL_XLEN-1:0] r;
        instr_t                ins;
        if (rst_left > 0) begin
            rst_left--;
            if (rst_left == 0) reset_i <= 1'b1;
        end else if (m_halt && reset_i) begin
            // Sit in halt a few cycles before the next reset
            halt_wait++;
            if (halt_wait == 3) begin
                halt_wait = 0;
                rst_left  = 4;
                reset_i  <= 1'b0;
            end
        end
        r        = $random(seed);
        flags_i <= r[`CTRL_FLAG_W-1:0];
        if (busy_left > 0) begin
            busy_left--;
            mem_busy_i <= 1'b1;
        end else if (r[7:5] == 3'b000) begin
            busy_left   = int'(r[9:8]);
            mem_busy_i <= 1'b1;
        end else mem_busy_i <= 1'b0;
        if (new_fetch) begin
            ins      = random_instr();
            m_ins    = ins;
            instr_i <= ins;
            n_instr++;
        end
    endtask

    initial begin
        seed       = 32'h761919ab;
        reset_i    = 1'b0;
        mem_busy_i = 1'b0;
        flags_i    = '0;
        instr_i    = '0;
        m_ins      = '0;
        m_main     = RESET;
        m_vec      = 0;
        m_step     = 0;
        m_len      = 0;
        m_halt     = 1'b0;
        ctrl_errs  = 0;
        bit_errs   = 0;
        n_instr    = 0;
        rst_left   = 4;
        halt_wait  = 0;
        busy_left  = 0;
        while (n_instr < N_INSTR) begin
            @(posedge clk_i);
            prev_main = m_main;
            advance_model();
            drive_inputs(m_main == FETCH && prev_main != FETCH);
            // Outputs settled half a cycle after the drive edge
            @(negedge clk_i);
            check_cycle();
        end
        $display("Errors: %0d control word, %0d ready/halt, %0d assertion, %0d instructions",
                 ctrl_errs, bit_errs, DUT.u_asserts.assert_fails, n_instr);
        if (ctrl_errs + bit_errs + DUT.u_asserts.assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
